// ==== src/fdiv_pkg.sv ====
// --------------------------------------
// fp32 divider types and constants
// fp32 only; specials other than zero are not decoded
// --------------------------------------

package fdiv_pkg;

  // --------------------------------------
  // divider constants
  // --------------------------------------
  localparam int unsigned EXP_BIAS    = 127;
  localparam int unsigned MANT_BITS   = 24;         // significand incl. hidden bit
  localparam int unsigned QUOT_BITS   = 25;         // one extra bit to normalize 0.5..2
  localparam int unsigned ITER_CYCLES = QUOT_BITS;  // one quotient bit per cycle

  // --------------------------------------
  // floating-point word
  // --------------------------------------
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;  // biased
    logic [22:0] fraction;  // hidden bit not stored
  } fp32_fields_t;

  // same 32 bits seen as raw word or as fields
  typedef union packed {
    logic [31:0]  bits;
    fp32_fields_t fields;
  } fp32_t;

  // ieee exception flags, msb first as in fflags
  typedef struct packed {
    logic nv;  // invalid, never set here
    logic dz;  // divide by zero
    logic of;  // overflow, never set here
    logic uf;  // underflow, never set here
    logic nx;  // inexact
  } status_t;

endpackage

// ==== src/fdiv_pipe.sv ====
// --------------------------------------
// elastic valid/ready register chain
// NUM_REGS = 0 gives a pass-through pipe
// --------------------------------------
`timescale 1ns/1ps

module fdiv_pipe #(
  parameter int unsigned NUM_REGS   = 1,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,   // drops every item in the chain
  // upstream side
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  // downstream side
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  // index i is the signal after i register stages
  logic [DATA_WIDTH-1:0] pipe_data_q  [0:NUM_REGS];
  logic                  pipe_valid_q [0:NUM_REGS];
  logic [0:NUM_REGS]     pipe_ready;  // combinational, runs backward

  assign pipe_data_q[0]  = data_i;
  assign pipe_valid_q[0] = valid_i;
  assign ready_o         = pipe_ready[0];

  // --------------------------------------
  // register stages
  // --------------------------------------
  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_stage
    logic stage_en;

    // advance when next stage moves on or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];
    assign stage_en      = pipe_ready[i] & pipe_valid_q[i];  // real item moves in

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;               // cancel in-flight items
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];    // bubble may be overwritten
      end
    end

    // payload only loads on a real transfer
    always_ff @(posedge clk_i) begin
      if (stage_en) begin
        pipe_data_q[i+1] <= pipe_data_q[i];
      end
    end
  end

  // last stage talks to downstream
  assign pipe_ready[NUM_REGS] = ready_i;
  assign data_o               = pipe_data_q[NUM_REGS];
  assign valid_o              = pipe_valid_q[NUM_REGS];

endmodule

// ==== src/fdiv_iter_counter.sv ====
// --------------------------------------
// iteration counter, ITER_CYCLES steps per start
// last_o follows the final step by one cycle
// --------------------------------------
`timescale 1ns/1ps

module fdiv_iter_counter (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,  // load, one cycle pulse
  input  logic abort_i,  // flush, stops the count
  output logic step_o,   // one quotient bit this cycle
  output logic last_o    // quotient complete
);

  localparam int unsigned CNT_W = $clog2(fdiv_pkg::ITER_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             last_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      last_q <= 1'b0;
    end else if (abort_i) begin
      cnt_q  <= '0;
      last_q <= 1'b0;
    end else begin
      last_q <= (cnt_q == CNT_W'(1));                // final step ends this cycle
      if (start_i) begin
        cnt_q <= CNT_W'(fdiv_pkg::ITER_CYCLES);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  assign step_o = (cnt_q != '0);
  assign last_o = last_q;

endmodule

// ==== src/fdiv_mant_core.sv ====
// --------------------------------------
// restoring divider, truncating fp32 quotient
// normal or zero operands only, exponent must stay in range
// --------------------------------------
`timescale 1ns/1ps

module fdiv_mant_core (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_i,   // capture operands
  input  logic              step_i,    // produce one quotient bit
  input  fdiv_pkg::fp32_t   a_i,       // dividend
  input  fdiv_pkg::fp32_t   b_i,       // divisor
  output fdiv_pkg::fp32_t   result_o,
  output fdiv_pkg::status_t status_o
);

  localparam int unsigned MW = fdiv_pkg::MANT_BITS;
  localparam int unsigned QW = fdiv_pkg::QUOT_BITS;

  // operand state
  logic          sign_q;
  logic [7:0]    exp_q;      // ea - eb + bias, wraps mod 256
  logic          a_zero_q;
  logic          b_zero_q;
  // iteration state
  logic [MW:0]   rem_q;      // partial remainder, always < 2 * divisor
  logic [MW-1:0] divisor_q;
  logic [QW-1:0] quot_q;     // msb has weight 1

  logic [MW:0]   rem_diff;
  logic          quot_bit;
  logic [7:0]    exp_norm;
  logic [MW-2:0] frac_norm;
  logic          lost_bit;

  // --------------------------------------
  // operand capture and iteration
  // --------------------------------------
  // flags and sign, reset so an idle core reads as +0
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sign_q   <= 1'b0;
      a_zero_q <= 1'b1;
      b_zero_q <= 1'b0;
    end else if (start_i) begin
      sign_q   <= a_i.fields.sign ^ b_i.fields.sign;
      a_zero_q <= (a_i.fields.exponent == '0);  // denormals treated as zero
      b_zero_q <= (b_i.fields.exponent == '0);
    end
  end

  // trial subtraction of the divisor
  assign rem_diff = rem_q - {1'b0, divisor_q};
  assign quot_bit = (rem_q >= {1'b0, divisor_q});

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      exp_q     <= a_i.fields.exponent - b_i.fields.exponent + 8'(fdiv_pkg::EXP_BIAS);
      rem_q     <= {1'b0, 1'b1, a_i.fields.fraction};  // hidden bit restored
      divisor_q <= {1'b1, b_i.fields.fraction};
      quot_q    <= '0;
    end else if (step_i) begin
      // keep or restore, then move to the next bit weight
      rem_q  <= quot_bit ? {rem_diff[MW-1:0], 1'b0} : {rem_q[MW-1:0], 1'b0};
      quot_q <= {quot_q[QW-2:0], quot_bit};
    end
  end

  // --------------------------------------
  // normalize and pack
  // --------------------------------------
  // quotient lies in 0.5..2, so at most one shift
  always_comb begin
    if (quot_q[QW-1]) begin
      frac_norm = quot_q[QW-2:1];  // 1.xxx form
      exp_norm  = exp_q;
      lost_bit  = quot_q[0];       // truncated away
    end else begin
      frac_norm = quot_q[QW-3:0];  // 0.1xxx, shift up one
      exp_norm  = exp_q - 8'd1;
      lost_bit  = 1'b0;
    end
  end

  always_comb begin
    result_o.fields.sign     = sign_q;
    result_o.fields.exponent = exp_norm;
    result_o.fields.fraction = frac_norm;
    status_o                 = '0;
    status_o.nx              = lost_bit | (rem_q != '0);  // any remainder means inexact
    // zero operands override the datapath
    if (a_zero_q) begin
      result_o.bits = {sign_q, 31'd0};         // signed zero, also taken for 0/0
      status_o      = '0;
    end else if (b_zero_q) begin
      result_o.bits = {sign_q, 8'hff, 23'd0};  // signed infinity
      status_o      = '0;
      status_o.dz   = 1'b1;
    end
  end

endmodule

// ==== src/fdiv_ctrl_fsm.sv ====
// --------------------------------------
// idle/busy/hold control around the divider core
// one division at a time, result held on stall
// --------------------------------------
`timescale 1ns/1ps

module fdiv_ctrl_fsm #(
  parameter int unsigned TAG_WIDTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // from input pipe
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [TAG_WIDTH-1:0] tag_i,
  // to counter and core
  output logic                 start_o,
  output logic                 abort_o,
  input  logic                 last_i,
  input  fdiv_pkg::fp32_t      unit_result_i,
  input  fdiv_pkg::status_t    unit_status_i,
  // to output pipe
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output fdiv_pkg::fp32_t      result_o,
  output fdiv_pkg::status_t    status_o,
  output logic [TAG_WIDTH-1:0] tag_o,
  output logic                 busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e                state_q;
  state_e                state_d;
  logic                  in_ready;
  logic                  out_valid;
  logic                  hold_result;   // capture the stalled result
  logic                  data_is_held;  // offer the held copy
  logic                  unit_busy;
  logic [TAG_WIDTH-1:0]  tag_q;
  fdiv_pkg::fp32_t       held_result_q;
  fdiv_pkg::status_t     held_status_q;

  // --------------------------------------
  // next state
  // --------------------------------------
  always_comb begin
    in_ready     = 1'b0;
    out_valid    = 1'b0;
    hold_result  = 1'b0;
    data_is_held = 1'b0;
    unit_busy    = 1'b0;
    state_d      = state_q;
    unique case (state_q)
      IDLE: begin
        in_ready = 1'b1;
        if (in_valid_i) state_d = BUSY;
      end
      BUSY: begin
        unit_busy = 1'b1;
        if (last_i) begin
          out_valid = 1'b1;               // quotient ready this cycle
          if (out_ready_i) begin
            in_ready = 1'b1;              // back-to-back accept
            state_d  = in_valid_i ? BUSY : IDLE;
          end else begin
            hold_result = 1'b1;           // downstream stalled
            state_d     = HOLD;
          end
        end
      end
      HOLD: begin
        unit_busy    = 1'b1;
        data_is_held = 1'b1;
        out_valid    = 1'b1;
        if (out_ready_i) begin
          in_ready = 1'b1;
          state_d  = in_valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // flush wins over everything
    if (flush_i) begin
      in_ready  = 1'b0;
      out_valid = 1'b0;
      unit_busy = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= IDLE;
    else          state_q <= state_d;
  end

  // --------------------------------------
  // tag and hold registers
  // --------------------------------------
  assign start_o = in_ready & in_valid_i;  // in_ready already low on flush

  always_ff @(posedge clk_i) begin
    if (start_o) tag_q <= tag_i;  // travels with the operation
  end

  always_ff @(posedge clk_i) begin
    if (hold_result) begin
      held_result_q <= unit_result_i;
      held_status_q <= unit_status_i;
    end
  end

  assign in_ready_o  = in_ready;
  assign abort_o     = flush_i;
  assign out_valid_o = out_valid;
  assign result_o    = data_is_held ? held_result_q : unit_result_i;
  assign status_o    = data_is_held ? held_status_q : unit_status_i;
  assign tag_o       = tag_q;
  assign busy_o      = unit_busy;

endmodule

// ==== src/fdiv_top.sv ====
// --------------------------------------
// fp32 divider with elastic in/out pipes
// busy_o sees only the last stage of each pipe
// --------------------------------------
`timescale 1ns/1ps

module fdiv_top #(
  parameter int unsigned NUM_INP_REGS = 1,
  parameter int unsigned NUM_OUT_REGS = 1,
  parameter int unsigned TAG_WIDTH    = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // input handshake
  input  fdiv_pkg::fp32_t      a_i,
  input  fdiv_pkg::fp32_t      b_i,
  input  logic [TAG_WIDTH-1:0] tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  // output handshake
  output fdiv_pkg::fp32_t      result_o,
  output fdiv_pkg::status_t    status_o,
  output logic [TAG_WIDTH-1:0] tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  localparam int unsigned INP_WIDTH = 2 * $bits(fdiv_pkg::fp32_t) + TAG_WIDTH;
  localparam int unsigned OUT_WIDTH = $bits(fdiv_pkg::fp32_t) + $bits(fdiv_pkg::status_t)
                                      + TAG_WIDTH;

  // input pipe to controller
  logic [INP_WIDTH-1:0] inp_data;
  logic                 inp_valid;
  logic                 inp_ready;
  fdiv_pkg::fp32_t      op_a;
  fdiv_pkg::fp32_t      op_b;
  logic [TAG_WIDTH-1:0] op_tag;
  // controller, counter and core
  logic                 start;
  logic                 abort;
  logic                 step;
  logic                 last;
  fdiv_pkg::fp32_t      unit_result;
  fdiv_pkg::status_t    unit_status;
  // controller to output pipe
  fdiv_pkg::fp32_t      ctrl_result;
  fdiv_pkg::status_t    ctrl_status;
  logic [TAG_WIDTH-1:0] ctrl_tag;
  logic                 ctrl_valid;
  logic                 ctrl_ready;
  logic                 ctrl_busy;

  // --------------------------------------
  // input side
  // --------------------------------------
  fdiv_pipe #(.NUM_REGS(NUM_INP_REGS), .DATA_WIDTH(INP_WIDTH)) u_inp_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .data_i ({a_i, b_i, tag_i}),
    .valid_i(in_valid_i), .ready_o(in_ready_o),
    .data_o (inp_data), .valid_o(inp_valid), .ready_i(inp_ready)
  );

  assign {op_a, op_b, op_tag} = inp_data;

  fdiv_ctrl_fsm #(.TAG_WIDTH(TAG_WIDTH)) u_ctrl_fsm (
    .clk_i, .rst_n_i, .flush_i,
    .in_valid_i(inp_valid), .in_ready_o(inp_ready), .tag_i(op_tag),
    .start_o(start), .abort_o(abort), .last_i(last),
    .unit_result_i(unit_result), .unit_status_i(unit_status),
    .out_valid_o(ctrl_valid), .out_ready_i(ctrl_ready),
    .result_o(ctrl_result), .status_o(ctrl_status), .tag_o(ctrl_tag),
    .busy_o(ctrl_busy)
  );

  fdiv_iter_counter u_iter_counter (
    .clk_i, .rst_n_i, .start_i(start), .abort_i(abort), .step_o(step), .last_o(last)
  );

  fdiv_mant_core u_mant_core (
    .clk_i, .rst_n_i, .start_i(start), .step_i(step), .a_i(op_a), .b_i(op_b),
    .result_o(unit_result), .status_o(unit_status)
  );

  // --------------------------------------
  // output side
  // --------------------------------------
  fdiv_pipe #(.NUM_REGS(NUM_OUT_REGS), .DATA_WIDTH(OUT_WIDTH)) u_out_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .data_i ({ctrl_result, ctrl_status, ctrl_tag}),
    .valid_i(ctrl_valid), .ready_o(ctrl_ready),
    .data_o ({result_o, status_o, tag_o}), .valid_o(out_valid_o), .ready_i(out_ready_i)
  );

  assign busy_o = ctrl_busy | inp_valid | out_valid_o;  // anything still in flight

endmodule

// ==== test/fdiv_sva.sv ====
// --------------------------------------
// handshake and flush checks, bound into fdiv_top
// error_cnt counts failed assertions
// --------------------------------------
`timescale 1ns/1ps

module fdiv_sva #(
  parameter int unsigned TAG_WIDTH = 4
) (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 flush_i,
  input logic                 in_ready_o,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic                 busy_o,
  input fdiv_pkg::fp32_t      result_o,
  input fdiv_pkg::status_t    status_o,
  input logic [TAG_WIDTH-1:0] tag_o
);

  int unsigned error_cnt = 0;

  // a stalled result keeps its valid and its data
  stall_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (out_valid_o && !out_ready_i && !flush_i)
      |=> (out_valid_o && $stable({result_o, status_o, tag_o})))
    else begin
      error_cnt++;
      $error("output changed while out_ready_i was low");
    end

  flush_clears_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_i |=> !out_valid_o)  // flushed item never shows up
    else begin
      error_cnt++;
      $error("out_valid_o high in the cycle after a flush");
    end

  // reset leaves an empty, ready unit
  reset_state_a: assert property (@(posedge clk_i)
      !rst_n_i |=> (!out_valid_o && !busy_o && in_ready_o))
    else begin
      error_cnt++;
      $error("unit not idle and ready after reset");
    end

endmodule

bind fdiv_top fdiv_sva #(.TAG_WIDTH(TAG_WIDTH)) u_fdiv_sva (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .flush_i    (flush_i),
  .in_ready_o (in_ready_o),
  .out_valid_o(out_valid_o),
  .out_ready_i(out_ready_i),
  .busy_o     (busy_o),
  .result_o   (result_o),
  .status_o   (status_o),
  .tag_o      (tag_o)
);

// ==== test/tb_fdiv_top.sv ====
// --------------------------------------
// table-driven testbench, expected quotients truncated
// inputs change on the falling edge, outputs taken at the rising edge
// --------------------------------------
`timescale 1ns/1ps

module tb_fdiv_top;

  localparam int unsigned TAG_W          = 4;
  localparam int unsigned NUM_ENTRIES    = 14;
  localparam int unsigned CLK_HALF       = 50;  // 100 ns period
  localparam int unsigned TIMEOUT_CYCLES = NUM_ENTRIES * (fdiv_pkg::ITER_CYCLES + 10) * 4;

  localparam logic [4:0] ST_OK = 5'b00000;
  localparam logic [4:0] ST_NX = 5'b00001;  // inexact
  localparam logic [4:0] ST_DZ = 5'b01000;  // divide by zero

  logic              clk_i;
  logic              rst_n_i;
  fdiv_pkg::fp32_t   a_i;
  fdiv_pkg::fp32_t   b_i;
  logic [TAG_W-1:0]  tag_i;
  logic              in_valid_i;
  logic              in_ready_o;
  logic              flush_i;
  fdiv_pkg::fp32_t   result_o;
  fdiv_pkg::status_t status_o;
  logic [TAG_W-1:0]  tag_o;
  logic              out_valid_o;
  logic              out_ready_i;
  logic              busy_o;

  // --------------------------------------
  // stimulus and expected values
  // --------------------------------------
  logic [31:0] tbl_a     [NUM_ENTRIES];
  logic [31:0] tbl_b     [NUM_ENTRIES];
  logic [31:0] tbl_res   [NUM_ENTRIES];
  logic [4:0]  tbl_st    [NUM_ENTRIES];
  bit          tbl_flush [NUM_ENTRIES];  // cancelled mid-division, no result

  fdiv_top #(.NUM_INP_REGS(1), .NUM_OUT_REGS(1), .TAG_WIDTH(TAG_W)) u_fdiv_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  // back-pressure in long random runs so results also wait in hold
  initial begin
    int unsigned run_len;
    out_ready_i = 1'b0;
    void'($urandom(37));
    forever begin
      run_len     = 1 + ($urandom % 40);
      out_ready_i = ($urandom % 2) != 0;
      repeat (run_len) @(negedge clk_i);
    end
  end

  // watchdog for hangs and for failed handshake assertions
  initial begin
    int unsigned cycles;
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (u_fdiv_top.u_fdiv_sva.error_cnt != 0) begin
        stop_on_error("handshake assertion failed in the bound checker");
      end
      if (cycles >= TIMEOUT_CYCLES) begin
        stop_on_error($sformatf("timeout, no completion after %0d cycles", cycles));
      end
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_on_error($sformatf("[ERROR] %s expected 0x%0h got 0x%0h", sig, expected, actual));
  endtask

  task automatic set_entry(input int idx, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] res, input logic [4:0] st, input bit flush);
    tbl_a[idx]     = a;
    tbl_b[idx]     = b;
    tbl_res[idx]   = res;
    tbl_st[idx]    = st;
    tbl_flush[idx] = flush;
  endtask

  task automatic fill_table();
    set_entry(0,  32'h40C00000, 32'h40000000, 32'h40400000, ST_OK, 0);  // 6 / 2
    set_entry(1,  32'hBF800000, 32'h40800000, 32'hBE800000, ST_OK, 0);  // -1 / 4
    set_entry(2,  32'h3F800000, 32'h40400000, 32'h3EAAAAAA, ST_NX, 0);  // 1 / 3
    set_entry(3,  32'h40000000, 32'h40400000, 32'h3F2AAAAA, ST_NX, 0);  // 2 / 3
    set_entry(4,  32'h41200000, 32'h40800000, 32'h40200000, ST_OK, 0);  // 10 / 4
    set_entry(5,  32'h40E00000, 32'hBF000000, 32'hC1600000, ST_OK, 0);  // 7 / -0.5
    set_entry(6,  32'h3F800000, 32'h41200000, 32'h3DCCCCCC, ST_NX, 0);  // 1 / 10
    set_entry(7,  32'h41100000, 32'h40400000, 32'h40400000, ST_OK, 1);  // 9 / 3, flushed
    set_entry(8,  32'h40400000, 32'h3FC00000, 32'h40000000, ST_OK, 0);  // 3 / 1.5
    set_entry(9,  32'h40A00000, 32'h00000000, 32'h7F800000, ST_DZ, 0);  // 5 / 0
    set_entry(10, 32'hC0400000, 32'h00000000, 32'hFF800000, ST_DZ, 0);  // -3 / 0
    set_entry(11, 32'h00000000, 32'h40200000, 32'h00000000, ST_OK, 0);  // 0 / 2.5
    set_entry(12, 32'h00000000, 32'hC0E00000, 32'h80000000, ST_OK, 0);  // 0 / -7
    set_entry(13, 32'h3F800000, 32'h40E00000, 32'h3E124924, ST_NX, 0);  // 1 / 7
  endtask

  // --------------------------------------
  // driver and checker
  // --------------------------------------
  // starts and ends on a falling edge
  task automatic send_op(input int idx);
    a_i.bits   = tbl_a[idx];
    b_i.bits   = tbl_b[idx];
    tag_i      = TAG_W'(idx);
    in_valid_i = 1'b1;
    do @(posedge clk_i); while (in_ready_o !== 1'b1);  // ready seen before the edge updates
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (busy_o !== 1'b0) @(negedge clk_i);
  endtask

  task automatic drive_table();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tbl_flush[i]) begin
        wait_idle();  // flush must hit only this op
        send_op(i);
        // done cycle, quotient offered to the empty output pipe
        repeat (fdiv_pkg::ITER_CYCLES + 1) @(negedge clk_i);
        assert (busy_o === 1'b1) else report_mismatch("busy_o", 32'd1, 32'(busy_o));
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        assert (busy_o === 1'b0) else report_mismatch("busy_o", 32'd0, 32'(busy_o));
        assert (out_valid_o === 1'b0) else report_mismatch("out_valid_o", 32'd0, 32'(out_valid_o));
      end else begin
        send_op(i);
      end
    end
  endtask

  // results in table order, flushed entries skipped
  task automatic check_results();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!tbl_flush[i]) begin
        do @(posedge clk_i); while (!(out_valid_o === 1'b1 && out_ready_i === 1'b1));
        assert (tag_o === TAG_W'(i)) else report_mismatch("tag_o", 32'(i), 32'(tag_o));
        assert (result_o.bits === tbl_res[i])
          else report_mismatch("result_o", tbl_res[i], result_o.bits);
        assert (status_o === tbl_st[i])
          else report_mismatch("status_o", 32'(tbl_st[i]), 32'(status_o));
      end
    end
  endtask

  initial begin
    rst_n_i    = 1'b0;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    a_i        = '0;
    b_i        = '0;
    tag_i      = '0;
    fill_table();
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    // idle unit before any input
    assert (out_valid_o === 1'b0) else report_mismatch("out_valid_o", 32'd0, 32'(out_valid_o));
    assert (busy_o === 1'b0) else report_mismatch("busy_o", 32'd0, 32'(busy_o));
    assert (in_ready_o === 1'b1) else report_mismatch("in_ready_o", 32'd1, 32'(in_ready_o));
    fork
      drive_table();
      check_results();
    join
    wait_idle();
    repeat (fdiv_pkg::ITER_CYCLES + 5) begin
      @(negedge clk_i);
      assert (out_valid_o === 1'b0) else stop_on_error("extra result after the last table entry");
    end
    if (u_fdiv_top.u_fdiv_sva.error_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d concurrent assertion failures in the handshake checks",
                              u_fdiv_top.u_fdiv_sva.error_cnt));
    end
  end

endmodule

// ==== compile.f ====
src/fdiv_pkg.sv
src/fdiv_pipe.sv
src/fdiv_iter_counter.sv
src/fdiv_mant_core.sv
src/fdiv_ctrl_fsm.sv
src/fdiv_top.sv
test/fdiv_sva.sv
test/tb_fdiv_top.sv

// ==== Bender.yml ====
package:
  name: fdiv

sources:
  - src/fdiv_pkg.sv
  - src/fdiv_pipe.sv
  - src/fdiv_iter_counter.sv
  - src/fdiv_mant_core.sv
  - src/fdiv_ctrl_fsm.sv
  - src/fdiv_top.sv
  - target: test
    files:
      - test/fdiv_sva.sv
      - test/tb_fdiv_top.sv
